/* logic/fifo_defs.svh */
// fifo sizing macros: word width, RAM geometry and almost-flag thresholds
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// ------------------------------
// data path
// ------------------------------
`define FIFO_DATA_W 16

// ------------------------------
// RAM geometry, one word per entry
// ------------------------------
`define FIFO_ADDR_W 4
`define FIFO_DEPTH 16

// almost flags, compared against RAM occupancy
`define FIFO_AFULL_LVL 12
`define FIFO_AEMPTY_LVL 2

`endif

/* logic/fifo_pkg.sv */
// fifo package with the RAM fill-state encoding
`default_nettype none

package fifo_pkg;

   // ------------------------------
   // RAM fill state
   // ------------------------------
   // nothing stored, no RAM read allowed
   // at least one word, not full
   // every entry holds a word, writes blocked
   typedef enum logic [1:0] {
      ST_EMPTY   = 2'b00,
      ST_PARTIAL = 2'b01,
      ST_FULL    = 2'b10
   } fill_state_t;

endpackage

`default_nettype wire

/* logic/fifo_rd_if.sv */
// fifo read link carrying RAM read request, status and data to the prefetch stage
`default_nettype none
`include "fifo_defs.svh"

interface fifo_rd_if;

   // read request from the prefetch stage
   logic                    fifo_rd_en;
   // RAM status from the level controller
   logic                    fifo_empty;
   logic                    fifo_aempty;
   // RAM word, one clock after the sampled request
   logic [`FIFO_DATA_W-1:0] fifo_dout;

   // core side, status and data out
   modport core (
      input  fifo_rd_en,
      output fifo_empty, fifo_aempty, fifo_dout
   );

   // prefetch side, request out
   modport stage (
      output fifo_rd_en,
      input  fifo_empty, fifo_aempty, fifo_dout
   );

endinterface

`default_nettype wire

/* logic/fifo_ptr_counter.sv */
// fifo pointer counter: RAM write and read addresses plus occupancy count
`default_nettype none
`include "fifo_defs.svh"

module fifo_ptr_counter (
   input  logic                   pos_rclk,
   input  logic                   aresetn_rclk,
   input  logic                   wr_push,
   input  logic                   rd_pop,
   output logic [`FIFO_ADDR_W-1:0] wr_addr,
   output logic [`FIFO_ADDR_W-1:0] rd_addr,
   output logic [`FIFO_ADDR_W:0]   count
);

   // step a pointer, wrapping after the last entry
   function automatic logic [`FIFO_ADDR_W-1:0] ptr_step(
      input logic [`FIFO_ADDR_W-1:0] ptr
   );
      logic [`FIFO_ADDR_W-1:0] last;
      last = (`FIFO_ADDR_W)'(`FIFO_DEPTH - 1);
      if (ptr == last)
         return '0;
      return ptr + 1'b1;
   endfunction

   // ------------------------------
   // pointers
   // ------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         wr_addr <= '0;
         rd_addr <= '0;
      end else begin
         // write side moves on accepted pushes only
         if (wr_push)
            wr_addr <= ptr_step(wr_addr);
         // read side moves on each RAM pop
         if (rd_pop)
            rd_addr <= ptr_step(rd_addr);
      end
   end

   // ------------------------------
   // occupancy
   // ------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         count <= '0;
      end else begin
         case ({wr_push, rd_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            // push and pop together, or idle
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/fifo_level_ctrl.sv */
// fifo level controller: fill-state FSM and registered full, almost and empty flags
`default_nettype none
`include "fifo_defs.svh"

module fifo_level_ctrl
   import fifo_pkg::*;
(
   input  logic                 pos_rclk,
   input  logic                 aresetn_rclk,
   input  logic                 wr_en,
   input  logic [`FIFO_ADDR_W:0] count,
   fifo_rd_if.core              rd,
   output logic                 wr_push,
   output logic                 rd_pop,
   output logic                 full,
   output logic                 afull
);

   fill_state_t             state;
   fill_state_t             state_nxt;
   logic [`FIFO_ADDR_W:0]   next_count;

   // writes dropped while full
   assign wr_push = wr_en & ~full;
   // stage only requests while the RAM is not empty
   assign rd_pop  = rd.fifo_rd_en;

   // occupancy after the coming edge
   always_comb begin
      next_count = count;
      if (wr_push & ~rd_pop)
         next_count = count + 1'b1;
      else if (rd_pop & ~wr_push)
         next_count = count - 1'b1;
   end

   // ------------------------------
   // fill-state FSM, tracks next_count
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_EMPTY:   if (next_count != '0) state_nxt = ST_PARTIAL;
         ST_PARTIAL: begin
            if (next_count == '0)
               state_nxt = ST_EMPTY;
            else if (next_count == (`FIFO_ADDR_W+1)'(`FIFO_DEPTH))
               state_nxt = ST_FULL;
         end
         ST_FULL:    if (next_count != (`FIFO_ADDR_W+1)'(`FIFO_DEPTH)) state_nxt = ST_PARTIAL;
         default:    state_nxt = ST_EMPTY;
      endcase
   end

   // flags set at once from the lookahead, clear one cycle after the count
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         state          <= ST_EMPTY;
         full           <= 1'b0;
         afull          <= 1'b0;
         rd.fifo_empty  <= 1'b1;
         rd.fifo_aempty <= 1'b1;
      end else begin
         state          <= state_nxt;
         full           <= (state == ST_FULL) | (state_nxt == ST_FULL);
         rd.fifo_empty  <= (state == ST_EMPTY) | (state_nxt == ST_EMPTY);
         afull          <= (count >= (`FIFO_ADDR_W+1)'(`FIFO_AFULL_LVL)) |
                           (next_count >= (`FIFO_ADDR_W+1)'(`FIFO_AFULL_LVL));
         rd.fifo_aempty <= (count <= (`FIFO_ADDR_W+1)'(`FIFO_AEMPTY_LVL)) |
                           (next_count <= (`FIFO_ADDR_W+1)'(`FIFO_AEMPTY_LVL));
      end
   end

endmodule

`default_nettype wire

/* logic/fifo_ram.sv */
// fifo storage: dual-port RAM with synchronous write and registered read
`default_nettype none
`include "fifo_defs.svh"

module fifo_ram (
   input  logic                    pos_rclk,
   input  logic                    wr_push,
   input  logic [`FIFO_ADDR_W-1:0] wr_addr,
   input  logic [`FIFO_DATA_W-1:0] din,
   input  logic                    rd_pop,
   input  logic [`FIFO_ADDR_W-1:0] rd_addr,
   output logic [`FIFO_DATA_W-1:0] rd_data
);

   logic [`FIFO_DATA_W-1:0] mem [0:`FIFO_DEPTH-1];

   // ------------------------------
   // write port
   // ------------------------------
   always_ff @(posedge pos_rclk) begin
      if (wr_push)
         mem[wr_addr] <= din;
   end

   // ------------------------------
   // read port
   // ------------------------------
   // output holds between pops
   // prefetch stage relies on that while its slots are full
   always_ff @(posedge pos_rclk) begin
      if (rd_pop)
         rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* logic/fifo_fwft_stage.sv */
// fifo fwft stage: three-slot prefetch keeping the oldest word at the output
`default_nettype none
`include "fifo_defs.svh"

module fifo_fwft_stage (
   input  logic                    pos_rclk,
   input  logic                    aresetn_rclk,
   fifo_rd_if.stage                rd,
   input  logic                    rd_en,
   output logic [`FIFO_DATA_W-1:0] dout,
   output logic                    dvld,
   output logic                    aempty
);

   // slot flags
   // RAM word in flight on fifo_dout
   logic                    fifo_valid;
   // parked word in the middle register
   logic                    middle_valid;
   // word presented on dout
   logic                    dout_valid;
   logic [`FIFO_DATA_W-1:0] middle_dout;
   logic                    update_dout;
   logic                    update_middle;

   // ------------------------------
   // slot steering
   // ------------------------------
   // load output when it is free or being consumed
   assign update_dout   = (fifo_valid | middle_valid) & (rd_en | ~dout_valid);
   // park the RAM word unless it goes straight out
   // middle full and moving out takes a fresh word behind it
   assign update_middle = fifo_valid & (middle_valid == update_dout);

   // pull from RAM unless all three slots hold a word
   assign rd.fifo_rd_en = ~rd.fifo_empty & ~(fifo_valid & middle_valid & dout_valid);

   // ------------------------------
   // payload registers
   // ------------------------------
   always_ff @(posedge pos_rclk) begin
      if (update_middle)
         middle_dout <= rd.fifo_dout;
      // middle word is older, so it goes first
      if (update_dout)
         dout <= middle_valid ? middle_dout : rd.fifo_dout;
   end

   // ------------------------------
   // slot flags
   // ------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         fifo_valid   <= 1'b0;
         middle_valid <= 1'b0;
         dout_valid   <= 1'b0;
      end else begin
         // new request keeps the in-flight slot busy
         if (rd.fifo_rd_en)
            fifo_valid <= 1'b1;
         else if (update_middle | update_dout)
            fifo_valid <= 1'b0;

         if (update_middle)
            middle_valid <= 1'b1;
         else if (update_dout)
            middle_valid <= 1'b0;

         // read with nothing behind empties the output
         if (update_dout)
            dout_valid <= 1'b1;
         else if (rd_en)
            dout_valid <= 1'b0;
      end
   end

   assign dvld   = dout_valid;
   // low RAM level or nothing presented
   assign aempty = rd.fifo_aempty | ~dout_valid;

endmodule

`default_nettype wire

/* logic/fifo_top.sv */
// fifo top: synchronous FWFT FIFO built from counter, level FSM, RAM and prefetch
`default_nettype none
`include "fifo_defs.svh"

module fifo_top (
   input  logic                    pos_rclk,
   input  logic                    aresetn_rclk,
   input  logic                    wr_en,
   input  logic [`FIFO_DATA_W-1:0] din,
   input  logic                    rd_en,
   output logic                    full,
   output logic                    afull,
   output logic [`FIFO_DATA_W-1:0] dout,
   output logic                    dvld,
   output logic                    empty,
   output logic                    aempty
);

   logic                    wr_push;
   logic                    rd_pop;
   logic [`FIFO_ADDR_W-1:0] wr_addr;
   logic [`FIFO_ADDR_W-1:0] rd_addr;
   logic [`FIFO_ADDR_W:0]   count;

   // core to prefetch link
   fifo_rd_if rd_if ();

   // ------------------------------
   // RAM side
   // ------------------------------
   fifo_ptr_counter u_ptr (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .wr_push      (wr_push),
      .rd_pop       (rd_pop),
      .wr_addr      (wr_addr),
      .rd_addr      (rd_addr),
      .count        (count)
   );

   fifo_level_ctrl u_ctrl (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .wr_en        (wr_en),
      .count        (count),
      .rd           (rd_if.core),
      .wr_push      (wr_push),
      .rd_pop       (rd_pop),
      .full         (full),
      .afull        (afull)
   );

   // RAM word lands on the link
   fifo_ram u_ram (
      .pos_rclk (pos_rclk),
      .wr_push  (wr_push),
      .wr_addr  (wr_addr),
      .din      (din),
      .rd_pop   (rd_pop),
      .rd_addr  (rd_addr),
      .rd_data  (rd_if.fifo_dout)
   );

   // ------------------------------
   // output side
   // ------------------------------
   fifo_fwft_stage u_fwft (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .rd           (rd_if.stage),
      .rd_en        (rd_en),
      .dout         (dout),
      .dvld         (dvld),
      .aempty       (aempty)
   );

   assign empty = ~dvld;

endmodule

`default_nettype wire

/* tests/fifo_tb.sv */
// fifo testbench: random write and read traffic checked against a queue model
`default_nettype none
`include "fifo_defs.svh"

module fifo_tb;

   localparam logic [31:0] LFSR_SEED = 32'h80ea;
   localparam int WRITE_LEN    = 300;
   localparam int READ_LEN     = 300;
   localparam int BAL_LEN      = 400;
   localparam int DIRECT_LEN   = 40;
   localparam int DRAIN_MARGIN = 200;
   localparam int TIMEOUT_CYCLES = WRITE_LEN + READ_LEN + BAL_LEN + DIRECT_LEN + DRAIN_MARGIN;
   localparam int MODE_WRITE = 0;
   localparam int MODE_READ  = 1;
   localparam int MODE_BAL   = 2;
   // words held at or above this always leave one on dout and the RAM above aempty
   localparam int HELD_LVL   = 8;

   logic                    pos_rclk;
   logic                    aresetn_rclk;
   logic                    wr_en;
   logic [`FIFO_DATA_W-1:0] din;
   logic                    rd_en;
   logic                    full;
   logic                    afull;
   logic [`FIFO_DATA_W-1:0] dout;
   logic                    dvld;
   logic                    empty;
   logic                    aempty;

   logic [31:0]             lfsr;
   logic [`FIFO_DATA_W-1:0] model_q[$];
   int                      error_count;
   int                      check_count;
   int                      cycle_count;

   fifo_top UUT (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .wr_en        (wr_en),
      .din          (din),
      .rd_en        (rd_en),
      .full         (full),
      .afull        (afull),
      .dout         (dout),
      .dvld         (dvld),
      .empty        (empty),
      .aempty       (aempty)
   );

   // ------------------------------
   // clock and watchdog
   // ------------------------------
   initial begin
      pos_rclk = 1'b0;
      forever #4 pos_rclk = ~pos_rclk;
   end

   // limit covers every phase plus the drain
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge pos_rclk);
         cycle_count++;
      end
      $display("ERROR: timeout after %0d cycles, traffic or drain never completed", cycle_count);
      $display("Finished with errors");
      $finish;
   end

   // ------------------------------
   // random source
   // ------------------------------
   // taps 32, 22, 2, 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [`FIFO_DATA_W-1:0] rand_word();
      logic [`FIFO_DATA_W-1:0] w;
      w = '0;
      for (int i = 0; i < `FIFO_DATA_W; i++)
         w = {w[`FIFO_DATA_W-2:0], lfsr_bit()};
      return w;
   endfunction

   // ------------------------------
   // reporting
   // ------------------------------
   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      error_count++;
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp)
         report_mismatch(name, 32'(exp), 32'(act));
   endtask

   // ------------------------------
   // one clock of traffic
   // ------------------------------
   // entered 1 unit after an edge, left 1 unit after the next
   task automatic run_cycle(input logic w, input logic r, input logic [`FIFO_DATA_W-1:0] d);
      logic                    hold_chk;
      logic [`FIFO_DATA_W-1:0] hold_val;
      wr_en = w;
      rd_en = r;
      din   = d;
      // everything settled mid-cycle
      @(negedge pos_rclk);
      hold_chk = rd_en & ~dvld;
      hold_val = dout;
      if (rd_en && dvld) begin
         check_count++;
         if (model_q.size() == 0) begin
            error_count++;
            $display("ERROR: read accepted while the model holds no word");
         end else begin
            if (dout !== model_q[0])
               report_mismatch("data_order", 32'(model_q[0]), 32'(dout));
            void'(model_q.pop_front());
         end
      end
      if (wr_en && !full)
         model_q.push_back(din);
      @(posedge pos_rclk);
      #1;
      // flags against the model after the edge
      if (model_q.size() >= `FIFO_DEPTH + 3)
         check_flag("overflow_full", 1'b1, full);
      if (model_q.size() < `FIFO_DEPTH)
         check_flag("overflow_full", 1'b0, full);
      if (model_q.size() >= `FIFO_AFULL_LVL + 3)
         check_flag("afull_high_level", 1'b1, afull);
      if (model_q.size() <= 1)
         check_flag("aempty_low_level", 1'b1, aempty);
      if (model_q.size() >= HELD_LVL) begin
         check_flag("dvld_held", 1'b1, dvld);
         check_flag("empty_held", 1'b0, empty);
         check_flag("aempty_held", 1'b0, aempty);
      end
      if (model_q.size() == 0)
         check_flag("empty_drained", 1'b1, empty);
      if (afull && model_q.size() < `FIFO_AFULL_LVL) begin
         error_count++;
         $display("ERROR: afull set with only %0d words held", model_q.size());
      end
      if (dvld && model_q.size() == 0) begin
         error_count++;
         $display("ERROR: dvld high with no word outstanding");
      end
      // read on an empty output leaves dout alone
      if (hold_chk && !dvld && dout !== hold_val)
         report_mismatch("underflow_hold", 32'(hold_val), 32'(dout));
   endtask

   // biased strobes per phase
   task automatic run_phase(input int mode, input int len);
      logic w;
      logic r;
      for (int i = 0; i < len; i++) begin
         if (mode == MODE_WRITE) begin
            w = lfsr_bit() | lfsr_bit();
            r = lfsr_bit() & lfsr_bit();
         end else if (mode == MODE_READ) begin
            w = lfsr_bit() & lfsr_bit();
            r = lfsr_bit() | lfsr_bit();
         end else begin
            w = lfsr_bit();
            r = lfsr_bit();
         end
         run_cycle(w, r, rand_word());
      end
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      logic [`FIFO_DATA_W-1:0] lat_word;
      error_count  = 0;
      check_count  = 0;
      lfsr         = LFSR_SEED;
      aresetn_rclk = 1'b0;
      wr_en        = 1'b0;
      rd_en        = 1'b0;
      din          = '0;
      repeat (3) @(posedge pos_rclk);
      #1 aresetn_rclk = 1'b1;

      // reset values
      check_flag("reset_dvld", 1'b0, dvld);
      check_flag("reset_full", 1'b0, full);
      check_flag("reset_afull", 1'b0, afull);
      check_flag("reset_empty", 1'b1, empty);
      check_flag("reset_aempty", 1'b1, aempty);

      // single write into the idle FIFO, visible after 3 edges
      lat_word = rand_word();
      run_cycle(1'b1, 1'b0, lat_word);
      check_flag("fwft_latency", 1'b0, dvld);
      for (int k = 1; k <= 3; k++) begin
         run_cycle(1'b0, 1'b0, '0);
         if (k < 3)
            check_flag("fwft_latency", 1'b0, dvld);
      end
      check_flag("fwft_latency", 1'b1, dvld);
      check_count++;
      if (dout !== lat_word)
         report_mismatch("fwft_latency_data", 32'(lat_word), 32'(dout));
      run_cycle(1'b0, 1'b1, '0);

      run_phase(MODE_WRITE, WRITE_LEN);
      run_phase(MODE_READ, READ_LEN);
      run_phase(MODE_BAL, BAL_LEN);

      // drain, reads only
      while (model_q.size() > 0)
         run_cycle(1'b0, 1'b1, '0);
      // stray reads on the empty FIFO
      repeat (10)
         run_cycle(1'b0, lfsr_bit(), '0);
      check_flag("drain_dvld", 1'b0, dvld);
      check_flag("drain_empty", 1'b1, empty);

      $display("errors: %0d, checks: %0d", error_count, check_count);
      if (error_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_rd_if.sv
logic/fifo_ptr_counter.sv
logic/fifo_level_ctrl.sv
logic/fifo_ram.sv
logic/fifo_fwft_stage.sv
logic/fifo_top.sv
tests/fifo_tb.sv

/* Makefile */
# Verilator build and run for the FWFT FIFO testbench

VERILATOR ?= verilator
TOP       ?= fifo_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
